// File: hdl/reg_bank_pkg.sv
// Register bank package
// Widths, address map, reset values and access-mode codes shared by the
// gate-driver control register bank
`default_nettype none

package reg_bank_pkg;

//========================================
// Widths and types
//========================================
localparam int REG_AW = 7;
localparam int REG_DW = 8;

typedef logic [REG_AW-1:0] reg_addr_t;
typedef logic [REG_DW-1:0] reg_data_t;
typedef logic [1:0]        acc_mode_t;

// Access modes with code 3 behaving as normal
localparam acc_mode_t ACC_NORMAL = 2'd0;
localparam acc_mode_t ACC_CFG    = 2'd1;
localparam acc_mode_t ACC_TEST   = 2'd2;

//========================================
// Address map
//========================================
localparam reg_addr_t ADDR_DEVICE_ID = 7'h00;
localparam reg_addr_t ADDR_MODE      = 7'h01;
localparam reg_addr_t ADDR_CONFIG1   = 7'h02;
localparam reg_addr_t ADDR_CONFIG2   = 7'h03;
localparam reg_addr_t ADDR_STATUS1   = 7'h08;
localparam reg_addr_t ADDR_MASK1     = 7'h09;
localparam reg_addr_t ADDR_STATUS2   = 7'h0A;
localparam reg_addr_t ADDR_MASK2     = 7'h0B;
localparam reg_addr_t ADDR_STATUS3   = 7'h0C;
localparam reg_addr_t ADDR_ADC1_LOW  = 7'h10;
localparam reg_addr_t ADDR_ADC1_HIGH = 7'h11;

// Reset values
localparam reg_data_t MODE_DEFAULT    = 8'h08;
localparam reg_data_t CONFIG1_DEFAULT = 8'h2B;
localparam reg_data_t CONFIG2_DEFAULT = 8'hFF;

// STATUS1 bit 6 has no source
localparam reg_data_t STATUS1_USED = 8'hBF;

// One select per register
typedef enum logic [3:0] {
    SEL_NONE,
    SEL_DEVICE_ID,
    SEL_MODE,
    SEL_CONFIG1,
    SEL_CONFIG2,
    SEL_STATUS1,
    SEL_MASK1,
    SEL_STATUS2,
    SEL_MASK2,
    SEL_STATUS3,
    SEL_ADC1_LOW,
    SEL_ADC1_HIGH
} reg_sel_t;

endpackage

`default_nettype wire

// File: hdl/reg_access_ctrl.sv
// Register access controller
// Decodes the register address, checks the access-mode permissions and
// returns registered write and read acknowledges
`default_nettype none

module reg_access_ctrl import reg_bank_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_reg_wen,
    input  logic      i_reg_ren,
    input  reg_addr_t i_reg_addr,
    input  reg_data_t i_reg_wdata,
    input  acc_mode_t i_acc_mode,
    output reg_sel_t  o_wr_sel,
    output reg_data_t o_wdata,
    output reg_sel_t  o_rd_sel,
    output logic      o_reg_wack,
    output logic      o_reg_rack
);

reg_sel_t  addr_sel;
logic      cfg_grp;
logic      sts_grp;
logic      wr_ok;
logic      rd_ok;
logic      rd_req;

//========================================
// Address decode
//========================================
always_comb begin
    case (i_reg_addr)
        ADDR_DEVICE_ID: addr_sel = SEL_DEVICE_ID;
        ADDR_MODE:      addr_sel = SEL_MODE;
        ADDR_CONFIG1:   addr_sel = SEL_CONFIG1;
        ADDR_CONFIG2:   addr_sel = SEL_CONFIG2;
        ADDR_STATUS1:   addr_sel = SEL_STATUS1;
        ADDR_MASK1:     addr_sel = SEL_MASK1;
        ADDR_STATUS2:   addr_sel = SEL_STATUS2;
        ADDR_MASK2:     addr_sel = SEL_MASK2;
        ADDR_STATUS3:   addr_sel = SEL_STATUS3;
        ADDR_ADC1_LOW:  addr_sel = SEL_ADC1_LOW;
        ADDR_ADC1_HIGH: addr_sel = SEL_ADC1_HIGH;
        default:        addr_sel = SEL_NONE;
    endcase
end

//========================================
// Mode permissions
//========================================
assign cfg_grp = addr_sel inside {SEL_MODE, SEL_CONFIG1, SEL_CONFIG2, SEL_MASK1, SEL_MASK2};
assign sts_grp = addr_sel inside {SEL_STATUS1, SEL_STATUS2};

always_comb begin
    case (i_acc_mode)
        ACC_TEST: begin
            wr_ok = cfg_grp;
            rd_ok = 1'b1;
        end
        ACC_CFG: begin
            wr_ok = cfg_grp | sts_grp;
            rd_ok = 1'b0;
        end
        // Unused code 3 folds into normal mode
        default: begin
            wr_ok = (addr_sel == SEL_MODE) | sts_grp;
            rd_ok = 1'b1;
        end
    endcase
end

// Write takes priority when both strobes are set
assign rd_req = i_reg_ren & ~i_reg_wen;

assign o_wr_sel = (i_reg_wen && wr_ok) ? addr_sel : SEL_NONE;
assign o_rd_sel = (rd_req && rd_ok) ? addr_sel : SEL_NONE;
assign o_wdata  = i_reg_wdata;

// Denied and unmapped accesses are still acknowledged
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_reg_wack <= 1'b0;
        o_reg_rack <= 1'b0;
    end else begin
        o_reg_wack <= i_reg_wen;
        o_reg_rack <= rd_req;
    end
end

endmodule

`default_nettype wire

// File: hdl/cfg_reg_file.sv
// Control register file
// Holds MODE, COM_CONFIG1/2 and MASK1/2, and turns a write of MODE bit 0
// into a one-cycle soft reset of the bank
`default_nettype none

module cfg_reg_file import reg_bank_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_sel_t  i_wr_sel,
    input  reg_data_t i_wdata,
    output reg_data_t o_mode,
    output reg_data_t o_config1,
    output reg_data_t o_config2,
    output reg_data_t o_mask1,
    output reg_data_t o_mask2,
    output logic      o_soft_rst
);

logic [REG_DW-1:1] mode_hi;
reg_data_t         config1;
reg_data_t         config2;
reg_data_t         mask1;
reg_data_t         mask2;
logic              soft_rst;
logic              bank_rst;

//========================================
// Soft reset request
//========================================
// Self-clearing pulse that drops a request made during the pulse
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        soft_rst <= 1'b0;
    end else begin
        soft_rst <= ~soft_rst & (i_wr_sel == SEL_MODE) & i_wdata[0];
    end
end

assign bank_rst = i_rst | soft_rst;

//========================================
// Writable control bytes
//========================================
always_ff @(posedge i_clk) begin
    if (bank_rst) begin
        mode_hi <= MODE_DEFAULT[REG_DW-1:1];
        config1 <= CONFIG1_DEFAULT;
        config2 <= CONFIG2_DEFAULT;
        mask1   <= '0;
        mask2   <= '0;
    end else begin
        case (i_wr_sel)
            SEL_MODE:    mode_hi <= i_wdata[REG_DW-1:1];
            SEL_CONFIG1: config1 <= i_wdata;
            SEL_CONFIG2: config2 <= i_wdata;
            SEL_MASK1:   mask1   <= i_wdata;
            SEL_MASK2:   mask2   <= i_wdata;
            default: ;
        endcase
    end
end

// Bit 0 of MODE carries the live soft reset pulse
assign o_mode     = {mode_hi, soft_rst};
assign o_config1  = config1;
assign o_config2  = config2;
assign o_mask1    = mask1;
assign o_mask2    = mask2;
assign o_soft_rst = soft_rst;

endmodule

`default_nettype wire

// File: hdl/status_reg_file.sv
// Sticky fault status registers
// STATUS1/STATUS2 capture hardware events, clear on write-1 and drive
// the interrupt through their masks
`default_nettype none

module status_reg_file import reg_bank_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_soft_rst,
    input  reg_sel_t  i_wr_sel,
    input  reg_data_t i_wdata,
    input  reg_data_t i_status1_evt,
    input  reg_data_t i_status2_evt,
    input  reg_data_t i_mask1,
    input  reg_data_t i_mask2,
    output reg_data_t o_status1,
    output reg_data_t o_status2,
    output logic      o_irq
);

reg_data_t status1;
reg_data_t status2;
reg_data_t clr1;
reg_data_t clr2;

// Write-1-to-clear vectors
assign clr1 = (i_wr_sel == SEL_STATUS1) ? i_wdata : '0;
assign clr2 = (i_wr_sel == SEL_STATUS2) ? i_wdata : '0;

//========================================
// Sticky capture
//========================================
// An event in the same cycle as a clear keeps its bit set
always_ff @(posedge i_clk) begin
    if (i_rst || i_soft_rst) begin
        status1 <= '0;
        status2 <= '0;
    end else begin
        status1 <= ((status1 & ~clr1) | i_status1_evt) & STATUS1_USED;
        status2 <= (status2 & ~clr2) | i_status2_evt;
    end
end

assign o_status1 = status1;
assign o_status2 = status2;

// Any unmasked fault raises the interrupt
assign o_irq = |((status1 & ~i_mask1) | (status2 & ~i_mask2));

endmodule

`default_nettype wire

// File: hdl/read_mux.sv
// Read data mux
// Picks one register, pin or ADC source by select and registers it as
// the read response
`default_nettype none

module read_mux import reg_bank_pkg::*; #(
    parameter int        ADC_W     = 10,
    parameter reg_data_t DEVICE_ID = 8'h5A
)(
    input  logic             i_clk,
    input  logic             i_rst,
    input  reg_sel_t         i_rd_sel,
    input  reg_data_t        i_mode,
    input  reg_data_t        i_config1,
    input  reg_data_t        i_config2,
    input  reg_data_t        i_mask1,
    input  reg_data_t        i_mask2,
    input  reg_data_t        i_status1,
    input  reg_data_t        i_status2,
    input  reg_data_t        i_io_pins,
    input  logic [ADC_W-1:0] i_adc1_data,
    output reg_data_t        o_rdata
);

reg_data_t adc_low;
reg_data_t adc_high;
reg_data_t rdata_nxt;

// Upper ADC bits zero-extended into one byte
assign adc_low  = i_adc1_data[REG_DW-1:0];
assign adc_high = reg_data_t'(i_adc1_data >> REG_DW);

always_comb begin
    case (i_rd_sel)
        SEL_DEVICE_ID: rdata_nxt = DEVICE_ID;
        SEL_MODE:      rdata_nxt = {i_mode[REG_DW-1:1], 1'b0};
        SEL_CONFIG1:   rdata_nxt = i_config1;
        SEL_CONFIG2:   rdata_nxt = i_config2;
        SEL_STATUS1:   rdata_nxt = i_status1;
        SEL_MASK1:     rdata_nxt = i_mask1;
        SEL_STATUS2:   rdata_nxt = i_status2;
        SEL_MASK2:     rdata_nxt = i_mask2;
        SEL_STATUS3:   rdata_nxt = i_io_pins;
        SEL_ADC1_LOW:  rdata_nxt = adc_low;
        SEL_ADC1_HIGH: rdata_nxt = adc_high;
        default:       rdata_nxt = '0;
    endcase
end

// Response register loads 00h whenever nothing is selected
always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_rdata <= '0;
    end else begin
        o_rdata <= rdata_nxt;
    end
end

endmodule

`default_nettype wire

// File: hdl/reg_bank_top.sv
// Register bank top level
// Connects the access controller to the config file, the sticky status
// file and the read data mux
`default_nettype none

module reg_bank_top import reg_bank_pkg::*; #(
    parameter int        ADC_W     = 10,
    parameter reg_data_t DEVICE_ID = 8'h5A
)(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_reg_wen,
    input  logic             i_reg_ren,
    input  reg_addr_t        i_reg_addr,
    input  reg_data_t        i_reg_wdata,
    input  acc_mode_t        i_acc_mode,
    input  reg_data_t        i_status1_evt,
    input  reg_data_t        i_status2_evt,
    input  reg_data_t        i_io_pins,
    input  logic [ADC_W-1:0] i_adc1_data,
    output logic             o_reg_wack,
    output logic             o_reg_rack,
    output reg_data_t        o_reg_rdata,
    output reg_data_t        o_mode,
    output reg_data_t        o_com_config1,
    output reg_data_t        o_com_config2,
    output logic             o_soft_rst,
    output logic             o_irq
);

reg_sel_t  wr_sel;
reg_sel_t  rd_sel;
reg_data_t wdata;
reg_data_t mask1;
reg_data_t mask2;
reg_data_t status1;
reg_data_t status2;

//========================================
// Access control
//========================================
reg_access_ctrl u_access_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_reg_wen   (i_reg_wen),
    .i_reg_ren   (i_reg_ren),
    .i_reg_addr  (i_reg_addr),
    .i_reg_wdata (i_reg_wdata),
    .i_acc_mode  (i_acc_mode),
    .o_wr_sel    (wr_sel),
    .o_wdata     (wdata),
    .o_rd_sel    (rd_sel),
    .o_reg_wack  (o_reg_wack),
    .o_reg_rack  (o_reg_rack)
);

//========================================
// Storage and read path
//========================================
cfg_reg_file u_cfg_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_wr_sel   (wr_sel),
    .i_wdata    (wdata),
    .o_mode     (o_mode),
    .o_config1  (o_com_config1),
    .o_config2  (o_com_config2),
    .o_mask1    (mask1),
    .o_mask2    (mask2),
    .o_soft_rst (o_soft_rst)
);

status_reg_file u_status_reg_file (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_soft_rst    (o_soft_rst),
    .i_wr_sel      (wr_sel),
    .i_wdata       (wdata),
    .i_status1_evt (i_status1_evt),
    .i_status2_evt (i_status2_evt),
    .i_mask1       (mask1),
    .i_mask2       (mask2),
    .o_status1     (status1),
    .o_status2     (status2),
    .o_irq         (o_irq)
);

read_mux #(
    .ADC_W     (ADC_W),
    .DEVICE_ID (DEVICE_ID)
) u_read_mux (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rd_sel    (rd_sel),
    .i_mode      (o_mode),
    .i_config1   (o_com_config1),
    .i_config2   (o_com_config2),
    .i_mask1     (mask1),
    .i_mask2     (mask2),
    .i_status1   (status1),
    .i_status2   (status2),
    .i_io_pins   (i_io_pins),
    .i_adc1_data (i_adc1_data),
    .o_rdata     (o_reg_rdata)
);

endmodule

`default_nettype wire

// File: testbench/tb_reg_bank.sv
// Register bank testbench
// Drives the access port with directed and random requests and checks
// every response against a shadow model of the register map
`default_nettype none

module tb_reg_bank import reg_bank_pkg::*; ();

localparam int        ADC_W         = 10;
localparam reg_data_t DEVICE_ID_VAL = 8'h5A;
localparam int        N_RAND        = 24;
localparam int        N_EVT         = 8;
localparam int        N_ADC         = 8;
// Request count of each section in test order
localparam int NUM_REQ = 13 + 2*N_RAND + 10 + 30 + 7*N_EVT + 2 + 3*N_ADC + 16 + 3;

// Mapped addresses followed by two holes in the map
localparam reg_addr_t MAP_ADDRS [13] = '{ADDR_DEVICE_ID, ADDR_MODE, ADDR_CONFIG1,
    ADDR_CONFIG2, ADDR_STATUS1, ADDR_MASK1, ADDR_STATUS2, ADDR_MASK2, ADDR_STATUS3,
    ADDR_ADC1_LOW, ADDR_ADC1_HIGH, 7'h04, 7'h7F};
localparam reg_addr_t CFG_ADDRS [4] = '{ADDR_CONFIG1, ADDR_CONFIG2, ADDR_MASK1, ADDR_MASK2};
localparam reg_addr_t RO_ADDRS [4]  = '{ADDR_DEVICE_ID, ADDR_STATUS3, 7'h05, 7'h7F};

logic             i_clk = 1'b0;
logic             i_rst;
logic             i_reg_wen;
logic             i_reg_ren;
reg_addr_t        i_reg_addr;
reg_data_t        i_reg_wdata;
acc_mode_t        i_acc_mode;
reg_data_t        i_status1_evt;
reg_data_t        i_status2_evt;
reg_data_t        i_io_pins;
logic [ADC_W-1:0] i_adc1_data;
logic             o_reg_wack;
logic             o_reg_rack;
reg_data_t        o_reg_rdata;
reg_data_t        o_mode;
reg_data_t        o_com_config1;
reg_data_t        o_com_config2;
logic             o_soft_rst;
logic             o_irq;

// Shadow register map and expected outputs
reg_data_t m_mode;
reg_data_t m_cfg1;
reg_data_t m_cfg2;
reg_data_t m_mask1;
reg_data_t m_mask2;
reg_data_t m_st1;
reg_data_t m_st2;
logic      m_soft;
logic      exp_wack;
logic      exp_rack;
logic      exp_irq;
reg_data_t exp_rdata;

// Values staged for the next falling edge
acc_mode_t        cur_mode;
reg_data_t        evt1_nxt;
reg_data_t        evt2_nxt;
reg_data_t        pins_nxt;
logic [ADC_W-1:0] adc_nxt;

always #10 i_clk = ~i_clk;

reg_bank_top #(
    .ADC_W     (ADC_W),
    .DEVICE_ID (DEVICE_ID_VAL)
) uut (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_reg_wen     (i_reg_wen),
    .i_reg_ren     (i_reg_ren),
    .i_reg_addr    (i_reg_addr),
    .i_reg_wdata   (i_reg_wdata),
    .i_acc_mode    (i_acc_mode),
    .i_status1_evt (i_status1_evt),
    .i_status2_evt (i_status2_evt),
    .i_io_pins     (i_io_pins),
    .i_adc1_data   (i_adc1_data),
    .o_reg_wack    (o_reg_wack),
    .o_reg_rack    (o_reg_rack),
    .o_reg_rdata   (o_reg_rdata),
    .o_mode        (o_mode),
    .o_com_config1 (o_com_config1),
    .o_com_config2 (o_com_config2),
    .o_soft_rst    (o_soft_rst),
    .o_irq         (o_irq)
);

task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "Stopped at the first failing check");
endtask

task automatic report_mismatch(input string name, input logic [15:0] got,
                               input logic [15:0] want);
    $display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, want);
    stop_run();
endtask

//========================================
// Reference model
//========================================
task automatic reset_model();
    m_mode  = 8'h08;
    m_cfg1  = 8'h2B;
    m_cfg2  = 8'hFF;
    m_mask1 = 8'h00;
    m_mask2 = 8'h00;
    m_st1   = 8'h00;
    m_st2   = 8'h00;
    m_soft  = 1'b0;
endtask

function automatic logic write_allowed(input reg_addr_t addr, input acc_mode_t mode);
    logic cfg_hit;
    logic sts_hit;
    cfg_hit = addr inside {ADDR_MODE, ADDR_CONFIG1, ADDR_CONFIG2, ADDR_MASK1, ADDR_MASK2};
    sts_hit = addr inside {ADDR_STATUS1, ADDR_STATUS2};
    case (mode)
        ACC_TEST: return cfg_hit;
        ACC_CFG:  return cfg_hit || sts_hit;
        // Mode code 3 acts as normal
        default:  return (addr == ADDR_MODE) || sts_hit;
    endcase
endfunction

function automatic reg_data_t expected_read(input reg_addr_t addr);
    if (cur_mode == ACC_CFG) begin
        return 8'h00;
    end
    case (addr)
        ADDR_DEVICE_ID: return DEVICE_ID_VAL;
        ADDR_MODE:      return m_mode;
        ADDR_CONFIG1:   return m_cfg1;
        ADDR_CONFIG2:   return m_cfg2;
        ADDR_STATUS1:   return m_st1;
        ADDR_MASK1:     return m_mask1;
        ADDR_STATUS2:   return m_st2;
        ADDR_MASK2:     return m_mask2;
        ADDR_STATUS3:   return pins_nxt;
        ADDR_ADC1_LOW:  return adc_nxt[7:0];
        ADDR_ADC1_HIGH: return reg_data_t'(adc_nxt[ADC_W-1:8]);
        default:        return 8'h00;
    endcase
endfunction

// State after one rising edge
task automatic update_model(input logic wen, input reg_addr_t addr, input reg_data_t wdata);
    logic      wr;
    reg_data_t clr1;
    reg_data_t clr2;
    wr   = wen && write_allowed(addr, cur_mode);
    clr1 = (wr && addr == ADDR_STATUS1) ? wdata : 8'h00;
    clr2 = (wr && addr == ADDR_STATUS2) ? wdata : 8'h00;
    if (m_soft) begin
        reset_model();
    end else begin
        if (wr) begin
            case (addr)
                ADDR_MODE:    m_mode  = {wdata[7:1], 1'b0};
                ADDR_CONFIG1: m_cfg1  = wdata;
                ADDR_CONFIG2: m_cfg2  = wdata;
                ADDR_MASK1:   m_mask1 = wdata;
                ADDR_MASK2:   m_mask2 = wdata;
                default: ;
            endcase
        end
        // Bit 6 of STATUS1 is not implemented
        m_st1  = ((m_st1 & ~clr1) | evt1_nxt) & 8'hBF;
        m_st2  = (m_st2 & ~clr2) | evt2_nxt;
        m_soft = wr && addr == ADDR_MODE && wdata[0];
    end
    exp_irq = |((m_st1 & ~m_mask1) | (m_st2 & ~m_mask2));
endtask

//========================================
// Stimulus
//========================================
task automatic cycle(input logic wen, input logic ren, input reg_addr_t addr,
                     input reg_data_t wdata);
    reg_data_t rd_exp;
    @(negedge i_clk);
    i_reg_wen     = wen;
    i_reg_ren     = ren;
    i_reg_addr    = addr;
    i_reg_wdata   = wdata;
    i_acc_mode    = cur_mode;
    i_status1_evt = evt1_nxt;
    i_status2_evt = evt2_nxt;
    i_io_pins     = pins_nxt;
    i_adc1_data   = adc_nxt;
    rd_exp = (ren && !wen) ? expected_read(addr) : 8'h00;
    @(posedge i_clk);
    update_model(wen, addr, wdata);
    exp_wack  = wen;
    exp_rack  = ren & ~wen;
    exp_rdata = rd_exp;
    // Events last a single cycle
    evt1_nxt  = 8'h00;
    evt2_nxt  = 8'h00;
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    cycle(1'b1, 1'b0, addr, data);
endtask

task automatic read_reg(input reg_addr_t addr);
    cycle(1'b0, 1'b1, addr, 8'h00);
endtask

task automatic idle();
    cycle(1'b0, 1'b0, 7'h00, 8'h00);
endtask

//========================================
// Checks sampled on the falling edge
//========================================
a_wack: assert property (@(negedge i_clk) disable iff (i_rst) o_reg_wack == exp_wack)
    else report_mismatch("o_reg_wack", 16'(o_reg_wack), 16'(exp_wack));
a_rack: assert property (@(negedge i_clk) disable iff (i_rst) o_reg_rack == exp_rack)
    else report_mismatch("o_reg_rack", 16'(o_reg_rack), 16'(exp_rack));
a_rdata: assert property (@(negedge i_clk) disable iff (i_rst) o_reg_rdata == exp_rdata)
    else report_mismatch("o_reg_rdata", 16'(o_reg_rdata), 16'(exp_rdata));
a_soft: assert property (@(negedge i_clk) disable iff (i_rst) o_soft_rst == m_soft)
    else report_mismatch("o_soft_rst", 16'(o_soft_rst), 16'(m_soft));
a_irq: assert property (@(negedge i_clk) disable iff (i_rst) o_irq == exp_irq)
    else report_mismatch("o_irq", 16'(o_irq), 16'(exp_irq));
a_mode: assert property (@(negedge i_clk) disable iff (i_rst)
                         o_mode == (m_mode | {7'd0, m_soft}))
    else report_mismatch("o_mode", 16'(o_mode), 16'(m_mode | {7'd0, m_soft}));
a_cfg1: assert property (@(negedge i_clk) disable iff (i_rst) o_com_config1 == m_cfg1)
    else report_mismatch("o_com_config1", 16'(o_com_config1), 16'(m_cfg1));
a_cfg2: assert property (@(negedge i_clk) disable iff (i_rst) o_com_config2 == m_cfg2)
    else report_mismatch("o_com_config2", 16'(o_com_config2), 16'(m_cfg2));

initial begin
    #((NUM_REQ + 50) * 20);
    $display("Watchdog timeout: the request sequence did not finish in time");
    stop_run();
end

initial begin
    logic [1:0] pick;
    reg_addr_t  addr;
    void'($urandom(64));
    i_rst         = 1'b1;
    i_reg_wen     = 1'b0;
    i_reg_ren     = 1'b0;
    i_reg_addr    = 7'h00;
    i_reg_wdata   = 8'h00;
    i_acc_mode    = ACC_NORMAL;
    i_status1_evt = 8'h00;
    i_status2_evt = 8'h00;
    i_io_pins     = 8'h00;
    i_adc1_data   = '0;
    cur_mode      = ACC_NORMAL;
    evt1_nxt      = 8'h00;
    evt2_nxt      = 8'h00;
    pins_nxt      = reg_data_t'($urandom);
    adc_nxt       = ADC_W'($urandom);
    exp_wack      = 1'b0;
    exp_rack      = 1'b0;
    exp_rdata     = 8'h00;
    exp_irq       = 1'b0;
    reset_model();
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    // Defaults after reset
    for (int i = 0; i < 13; i++) begin
        read_reg(MAP_ADDRS[i]);
    end

    // Test mode config and mask traffic
    cur_mode = ACC_TEST;
    repeat (N_RAND) begin
        pick = 2'($urandom);
        addr = CFG_ADDRS[pick];
        write_reg(addr, reg_data_t'($urandom));
        read_reg(addr);
    end
    for (int i = 0; i < 4; i++) begin
        write_reg(RO_ADDRS[i], reg_data_t'($urandom));
        read_reg(RO_ADDRS[i]);
    end
    cycle(1'b1, 1'b1, ADDR_CONFIG1, 8'hC3);
    read_reg(ADDR_CONFIG1);

    //========================================
    // Permission table
    //========================================
    cur_mode = ACC_CFG;
    for (int i = 0; i < 13; i++) begin
        read_reg(MAP_ADDRS[i]);
    end
    write_reg(ADDR_CONFIG2, 8'h5C);
    write_reg(ADDR_MASK1, 8'hF0);
    cur_mode = ACC_NORMAL;
    for (int i = 0; i < 4; i++) begin
        write_reg(CFG_ADDRS[i], reg_data_t'($urandom));
        read_reg(CFG_ADDRS[i]);
    end
    cur_mode = 2'd3;
    write_reg(ADDR_CONFIG1, 8'h77);
    read_reg(ADDR_CONFIG1);
    evt1_nxt = 8'hFF;
    evt2_nxt = 8'hFF;
    idle();
    cur_mode = ACC_TEST;
    write_reg(ADDR_STATUS1, 8'hFF);
    write_reg(ADDR_STATUS2, 8'hFF);
    read_reg(ADDR_STATUS1);
    read_reg(ADDR_STATUS2);

    // Sticky events with write-1 clears and the masked interrupt
    cur_mode = ACC_NORMAL;
    repeat (N_EVT) begin
        evt1_nxt = reg_data_t'($urandom);
        evt2_nxt = reg_data_t'($urandom);
        idle();
        read_reg(ADDR_STATUS1);
        read_reg(ADDR_STATUS2);
        write_reg(ADDR_STATUS1, reg_data_t'($urandom));
        write_reg(ADDR_STATUS2, reg_data_t'($urandom));
        cur_mode = ACC_CFG;
        write_reg(ADDR_MASK1, reg_data_t'($urandom));
        write_reg(ADDR_MASK2, reg_data_t'($urandom));
        cur_mode = ACC_NORMAL;
    end
    evt1_nxt = 8'h81;
    write_reg(ADDR_STATUS1, 8'hFF);
    read_reg(ADDR_STATUS1);

    // Live pins and ADC bytes
    repeat (N_ADC) begin
        pins_nxt = reg_data_t'($urandom);
        adc_nxt  = ADC_W'($urandom);
        read_reg(ADDR_STATUS3);
        read_reg(ADDR_ADC1_LOW);
        read_reg(ADDR_ADC1_HIGH);
    end

    //========================================
    // Soft reset
    //========================================
    cur_mode = ACC_TEST;
    for (int i = 0; i < 4; i++) begin
        write_reg(CFG_ADDRS[i], reg_data_t'($urandom));
    end
    evt1_nxt = 8'h3C;
    evt2_nxt = 8'hC3;
    idle();
    cur_mode = ACC_NORMAL;
    write_reg(ADDR_MODE, 8'hF1);
    // Lands on the reset edge and is lost
    write_reg(ADDR_MODE, 8'h55);
    cur_mode = ACC_TEST;
    for (int i = 1; i < 8; i++) begin
        read_reg(MAP_ADDRS[i]);
    end
    write_reg(ADDR_MODE, 8'hA6);
    read_reg(ADDR_MODE);

    repeat (3) idle();
    @(negedge i_clk);
    #1;
    $display("All tests passed!");
    $finish;
end

endmodule

`default_nettype wire

// File: tb.f
hdl/reg_bank_pkg.sv
hdl/reg_access_ctrl.sv
hdl/cfg_reg_file.sv
hdl/status_reg_file.sv
hdl/read_mux.sv
hdl/reg_bank_top.sv
testbench/tb_reg_bank.sv

// File: run.sh
#!/bin/sh
# Builds the register bank testbench with Verilator and runs it

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_reg_bank -f tb.f \
    && ./obj_dir/Vtb_reg_bank 2>&1 | tee sim.log \
    || echo "Test failures found" >> sim.log

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
